// File: Bender.yml
package:
  name: catch_game

sources:
  - include_dirs:
      - include
    files:
      - src/catch_pkg.sv
      - src/player_motion.sv
      - src/apple_dropper.sv
      - src/game_fsm.sv
      - src/pixel_painter.sv
      - src/catch_game_top.sv
  - target: test
    files:
      - verif/catch_game_properties.sv
      - verif/tb_catch_game.sv

// File: build.f
+incdir+include
src/catch_pkg.sv
src/player_motion.sv
src/apple_dropper.sv
src/game_fsm.sv
src/pixel_painter.sv
src/catch_game_top.sv
verif/catch_game_properties.sv
verif/tb_catch_game.sv

// File: include/spawn_table.svh
`ifndef SPAWN_TABLE_SVH
`define SPAWN_TABLE_SVH

// respawn points, walked in order after every catch or miss
localparam int spawn_len = 16;

localparam logic [catch_pkg::coord_w-1:0] spawn_x [spawn_len] = '{
	10'd300, 10'd450, 10'd770, 10'd470,
	10'd150, 10'd665, 10'd540, 10'd590,
	10'd400, 10'd200, 10'd250, 10'd665,
	10'd200, 10'd750, 10'd400, 10'd450
};

localparam logic [catch_pkg::coord_w-1:0] spawn_y [spawn_len] = '{
	10'd255, 10'd50, 10'd100, 10'd190,
	10'd200, 10'd215, 10'd90, 10'd222,
	10'd255, 10'd200, 10'd70, 10'd300,
	10'd90, 10'd222, 10'd40, 10'd200
};

`endif

// File: src/apple_dropper.sv
`timescale 1ns/100ps
`default_nettype none

module apple_dropper (
	input wire logic clk,
	input wire logic rst,
	input wire catch_pkg::level_e level,
	input wire logic [catch_pkg::coord_w-1:0] player_x,
	input wire logic [catch_pkg::coord_w-1:0] player_y,
	output logic [catch_pkg::coord_w-1:0] apple_x,
	output logic [catch_pkg::coord_w-1:0] apple_y,
	output logic caught,
	output logic missed
);

	`include "spawn_table.svh"

	logic [$clog2(spawn_len)-1:0] spawn_idx;
	logic [catch_pkg::coord_w-1:0] fall;
	logic hit;

	// fall step per level
	always_comb
	begin
		case (level)
			catch_pkg::lvl_one: fall = catch_pkg::fall_speed_one;
			catch_pkg::lvl_two: fall = catch_pkg::fall_speed_two;
			catch_pkg::lvl_three: fall = catch_pkg::fall_speed_three;
			default: fall = '0;
		endcase
	end

	// player centre inside the apple box
	// sums on the far side keep the compare free of underflow
	assign hit = (player_x + catch_pkg::apple_half >= apple_x) &&
		(player_x <= apple_x + catch_pkg::apple_half) &&
		(player_y + catch_pkg::apple_half >= apple_y) &&
		(player_y <= apple_y + catch_pkg::apple_half);

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			apple_x <= catch_pkg::apple_start_x;
			apple_y <= catch_pkg::apple_start_y;
			spawn_idx <= '0;
			caught <= 1'b0;
			missed <= 1'b0;
		end
		else
		begin
			caught <= 1'b0;
			missed <= 1'b0;
			if (level == catch_pkg::lvl_idle)
			begin
				apple_x <= catch_pkg::apple_start_x;
				apple_y <= catch_pkg::apple_start_y;
				spawn_idx <= '0;
			end
			else if (catch_pkg::is_play(level))
			begin
				// catch wins over a miss in the same cycle
				if (hit || (apple_y > catch_pkg::apple_floor))
				begin
					caught <= hit;
					missed <= !hit;
					apple_x <= spawn_x[spawn_idx];
					apple_y <= spawn_y[spawn_idx];
					// 4-bit index wraps 15 -> 0 by itself
					spawn_idx <= spawn_idx + 1'b1;
				end
				else
					apple_y <= apple_y + fall;
			end
			// lvl_over keeps everything frozen
		end
	end

endmodule

`default_nettype wire

// File: src/catch_game_top.sv
`timescale 1ns/100ps
`default_nettype none

module catch_game_top (
	input wire logic clk,
	input wire logic rst,
	input wire logic bright,
	input wire logic up,
	input wire logic down,
	input wire logic left,
	input wire logic right,
	input wire logic [catch_pkg::coord_w-1:0] hcount,
	input wire logic [catch_pkg::coord_w-1:0] vcount,
	output logic [catch_pkg::rgb_w-1:0] rgb,
	output logic [catch_pkg::rgb_w-1:0] background
);

	catch_pkg::level_e level;
	logic [catch_pkg::coord_w-1:0] player_x;
	logic [catch_pkg::coord_w-1:0] player_y;
	logic [catch_pkg::coord_w-1:0] apple_x;
	logic [catch_pkg::coord_w-1:0] apple_y;
	logic caught;
	logic missed;
	logic [catch_pkg::lives_w-1:0] lives;
	logic [catch_pkg::bar_count_w-1:0] level_catches;

	player_motion i_player_motion (
		.clk(clk), .rst(rst), .level(level),
		.up(up), .down(down), .left(left), .right(right),
		.player_x(player_x), .player_y(player_y)
	);

	apple_dropper i_apple_dropper (
		.clk(clk), .rst(rst), .level(level),
		.player_x(player_x), .player_y(player_y),
		.apple_x(apple_x), .apple_y(apple_y),
		.caught(caught), .missed(missed)
	);

	game_fsm i_game_fsm (
		.clk(clk), .rst(rst), .left(left), .right(right),
		.caught(caught), .missed(missed), .level(level), .lives(lives),
		.level_catches(level_catches), .background(background)
	);

	pixel_painter i_pixel_painter (
		.bright(bright), .hcount(hcount), .vcount(vcount), .level(level),
		.player_x(player_x), .player_y(player_y), .apple_x(apple_x), .apple_y(apple_y),
		.lives(lives), .level_catches(level_catches), .background(background), .rgb(rgb)
	);

endmodule

`default_nettype wire

// File: src/catch_pkg.sv
`default_nettype none

package catch_pkg;

	localparam int coord_w = 10;
	localparam int rgb_w = 12;
	localparam int lives_w = 3;
	localparam int bar_count_w = 4;

	// game phase, idle screen through end screen
	typedef enum logic [2:0] {
		lvl_idle,
		lvl_one,
		lvl_two,
		lvl_three,
		lvl_over
	} level_e;

	// playfield wrap bounds
	localparam logic [coord_w-1:0] play_x_min = 10'd150;
	localparam logic [coord_w-1:0] play_x_max = 10'd800;
	localparam logic [coord_w-1:0] play_y_min = 10'd34;
	localparam logic [coord_w-1:0] play_y_max = 10'd514;

	localparam logic [coord_w-1:0] player_start_x = 10'd450;
	localparam logic [coord_w-1:0] player_start_y = 10'd250;
	localparam logic [coord_w-1:0] player_step = 10'd2;
	localparam logic [coord_w-1:0] player_half = 10'd5;

	// apple box half size, doubles as the catch window
	localparam logic [coord_w-1:0] apple_half = 10'd10;
	localparam logic [coord_w-1:0] apple_start_x = 10'd400;
	localparam logic [coord_w-1:0] apple_start_y = 10'd200;
	localparam logic [coord_w-1:0] apple_floor = 10'd520;

	localparam logic [coord_w-1:0] fall_speed_one = 10'd1;
	localparam logic [coord_w-1:0] fall_speed_two = 10'd2;
	localparam logic [coord_w-1:0] fall_speed_three = 10'd3;

	localparam logic [bar_count_w-1:0] goal_one = 4'd7;
	localparam logic [bar_count_w-1:0] goal_two = 4'd8;
	localparam logic [lives_w-1:0] max_lives = 3'd5;

	localparam logic [rgb_w-1:0] col_black = 12'h000;
	localparam logic [rgb_w-1:0] col_white = 12'hFFF;
	localparam logic [rgb_w-1:0] col_red = 12'hF00;
	localparam logic [rgb_w-1:0] col_green = 12'h0F0;
	localparam logic [rgb_w-1:0] col_grey = 12'hCCC;
	localparam logic [rgb_w-1:0] bg_one = 12'h30C;
	localparam logic [rgb_w-1:0] bg_two = 12'hCC0;
	localparam logic [rgb_w-1:0] bg_three = 12'h00F;

	// lives bar, one segment per life
	localparam int lives_x0 = 721;
	localparam int lives_seg_w = 10;
	localparam int lives_pitch = 10;
	localparam int lives_y_top = 50;
	localparam int lives_y_bot = 100;

	// progress bar, one row per catch
	localparam int bar_x_lo = 155;
	localparam int bar_x_hi = 179;
	localparam int bar_y0 = 50;
	localparam int bar_row_h = 11;
	localparam int bar_pitch = 12;
	localparam int bar_rows = 9;

	function automatic logic is_play(input level_e lvl);
		return (lvl == lvl_one) || (lvl == lvl_two) || (lvl == lvl_three);
	endfunction

endpackage

`default_nettype wire

// File: src/game_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module game_fsm (
	input wire logic clk,
	input wire logic rst,
	input wire logic left,
	input wire logic right,
	input wire logic caught,
	input wire logic missed,
	output catch_pkg::level_e level,
	output logic [catch_pkg::lives_w-1:0] lives,
	output logic [catch_pkg::bar_count_w-1:0] level_catches,
	output logic [catch_pkg::rgb_w-1:0] background
);

	logic start;
	logic goal_hit;

	// both side buttons together start a game
	assign start = left && right;

	// count reached this level's goal on the previous catch
	assign goal_hit = ((level == catch_pkg::lvl_one) && (level_catches == catch_pkg::goal_one)) ||
		((level == catch_pkg::lvl_two) && (level_catches == catch_pkg::goal_two));

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			level <= catch_pkg::lvl_idle;
			lives <= catch_pkg::max_lives;
			level_catches <= '0;
		end
		else
		begin
			case (level)
				catch_pkg::lvl_idle,
				catch_pkg::lvl_over:
				begin
					if (start)
					begin
						level <= catch_pkg::lvl_one;
						lives <= catch_pkg::max_lives;
						level_catches <= '0;
					end
				end
				catch_pkg::lvl_one,
				catch_pkg::lvl_two,
				catch_pkg::lvl_three:
				begin
					if (lives == '0)
						level <= catch_pkg::lvl_over;
					else if (goal_hit)
					begin
						// next level starts with a fresh bar and full lives
						level <= (level == catch_pkg::lvl_one) ? catch_pkg::lvl_two :
							catch_pkg::lvl_three;
						level_catches <= '0;
						lives <= catch_pkg::max_lives;
					end
					else if (caught)
					begin
						// level three has no goal, so hold at the top
						if (level_catches != '1)
							level_catches <= level_catches + 1'b1;
					end
					else if (missed)
						lives <= lives - 1'b1;
				end
				default:
					level <= catch_pkg::lvl_idle;
			endcase
		end
	end

	// screen colour per phase
	always_comb
	begin
		case (level)
			catch_pkg::lvl_one: background = catch_pkg::bg_one;
			catch_pkg::lvl_two: background = catch_pkg::bg_two;
			catch_pkg::lvl_three: background = catch_pkg::bg_three;
			catch_pkg::lvl_over: background = catch_pkg::col_black;
			default: background = catch_pkg::col_white;
		endcase
	end

endmodule

`default_nettype wire

// File: src/pixel_painter.sv
`timescale 1ns/100ps
`default_nettype none

module pixel_painter (
	input wire logic bright,
	input wire logic [catch_pkg::coord_w-1:0] hcount,
	input wire logic [catch_pkg::coord_w-1:0] vcount,
	input wire catch_pkg::level_e level,
	input wire logic [catch_pkg::coord_w-1:0] player_x,
	input wire logic [catch_pkg::coord_w-1:0] player_y,
	input wire logic [catch_pkg::coord_w-1:0] apple_x,
	input wire logic [catch_pkg::coord_w-1:0] apple_y,
	input wire logic [catch_pkg::lives_w-1:0] lives,
	input wire logic [catch_pkg::bar_count_w-1:0] level_catches,
	input wire logic [catch_pkg::rgb_w-1:0] background,
	output logic [catch_pkg::rgb_w-1:0] rgb
);

	logic in_player;
	logic in_apple;
	logic lives_hit;
	logic lives_lit;
	logic bar_hit;
	logic bar_lit;
	logic game_over;

	assign game_over = (level == catch_pkg::lvl_over);

	assign in_player = (hcount + catch_pkg::player_half >= player_x) &&
		(hcount <= player_x + catch_pkg::player_half) &&
		(vcount + catch_pkg::player_half >= player_y) &&
		(vcount <= player_y + catch_pkg::player_half);

	assign in_apple = (hcount + catch_pkg::apple_half >= apple_x) &&
		(hcount <= apple_x + catch_pkg::apple_half) &&
		(vcount + catch_pkg::apple_half >= apple_y) &&
		(vcount <= apple_y + catch_pkg::apple_half);

	// find which bar segment the scan sits on, if any
	always_comb
	begin
		lives_hit = 1'b0;
		lives_lit = 1'b0;
		bar_hit = 1'b0;
		bar_lit = 1'b0;
		for (int k = 0; k < catch_pkg::max_lives; k++)
		begin
			if ((hcount >= catch_pkg::lives_x0 + k * catch_pkg::lives_pitch) &&
				(hcount < catch_pkg::lives_x0 + k * catch_pkg::lives_pitch +
				catch_pkg::lives_seg_w) &&
				(vcount >= catch_pkg::lives_y_top) && (vcount <= catch_pkg::lives_y_bot))
			begin
				lives_hit = 1'b1;
				lives_lit = (k < lives);
			end
		end
		for (int k = 0; k < catch_pkg::bar_rows; k++)
		begin
			if ((hcount >= catch_pkg::bar_x_lo) && (hcount <= catch_pkg::bar_x_hi) &&
				(vcount >= catch_pkg::bar_y0 + k * catch_pkg::bar_pitch) &&
				(vcount < catch_pkg::bar_y0 + k * catch_pkg::bar_pitch + catch_pkg::bar_row_h))
			begin
				bar_hit = 1'b1;
				bar_lit = (k < level_catches);
			end
		end
	end

	// priority mux, blanking first
	always_comb
	begin
		if (!bright)
			rgb = catch_pkg::col_black;
		else if (in_player)
			rgb = catch_pkg::col_red;
		else if (in_apple)
			rgb = catch_pkg::col_green;
		else if (lives_hit)
			rgb = game_over ? catch_pkg::col_black : (lives_lit ? catch_pkg::col_grey : background);
		else if (bar_hit)
			rgb = game_over ? catch_pkg::col_black : (bar_lit ? catch_pkg::col_red : background);
		else
			rgb = background;
	end

endmodule

`default_nettype wire

// File: src/player_motion.sv
`timescale 1ns/100ps
`default_nettype none

module player_motion (
	input wire logic clk,
	input wire logic rst,
	input wire catch_pkg::level_e level,
	input wire logic up,
	input wire logic down,
	input wire logic left,
	input wire logic right,
	output logic [catch_pkg::coord_w-1:0] player_x,
	output logic [catch_pkg::coord_w-1:0] player_y
);

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			player_x <= catch_pkg::player_start_x;
			player_y <= catch_pkg::player_start_y;
		end
		else if (catch_pkg::is_play(level))
		begin
			// one direction per cycle, right first
			if (right)
			begin
				if (player_x == catch_pkg::play_x_max)
					player_x <= catch_pkg::play_x_min;
				else
					player_x <= player_x + catch_pkg::player_step;
			end
			else if (left)
			begin
				if (player_x == catch_pkg::play_x_min)
					player_x <= catch_pkg::play_x_max;
				else
					player_x <= player_x - catch_pkg::player_step;
			end
			else if (up)
			begin
				if (player_y == catch_pkg::play_y_min)
					player_y <= catch_pkg::play_y_max;
				else
					player_y <= player_y - catch_pkg::player_step;
			end
			else if (down)
			begin
				// bottom edge wraps to the top
				if (player_y == catch_pkg::play_y_max)
					player_y <= catch_pkg::play_y_min;
				else
					player_y <= player_y + catch_pkg::player_step;
			end
		end
	end

endmodule

`default_nettype wire

// File: verif/catch_game_properties.sv
`timescale 1ns/100ps
`default_nettype none

module catch_game_properties (
	input wire logic clk,
	input wire logic rst,
	input wire catch_pkg::level_e level,
	input wire logic [catch_pkg::lives_w-1:0] lives,
	input wire logic caught,
	input wire logic missed
);

	int assert_failures = 0;

	// lives capped at a full bar
	assert property (@(posedge clk) disable iff (rst) lives <= catch_pkg::max_lives)
	else
	begin
		$error("lives count above the maximum");
		assert_failures++;
	end

	// last life gone in a play level ends the game one edge later
	assert property (@(posedge clk) disable iff (rst)
		((level == catch_pkg::lvl_one || level == catch_pkg::lvl_two ||
		level == catch_pkg::lvl_three) && lives == '0) |=> (level == catch_pkg::lvl_over))
	else
	begin
		$error("no end screen after the last life");
		assert_failures++;
	end

	assert property (@(posedge clk) disable iff (rst) !(caught && missed))
	else
	begin
		$error("catch and miss pulses in the same cycle");
		assert_failures++;
	end

endmodule

bind game_fsm catch_game_properties i_catch_game_properties (
	.clk(clk), .rst(rst), .level(level), .lives(lives), .caught(caught), .missed(missed)
);

`default_nettype wire

// File: verif/catch_trace.txt
# test op up down left right bright hcount vcount cycles rgb background
# op d holds the inputs for the cycles, op p checks rgb and background in hex
reset_view p 0 0 0 0 1 450 250 0 F00 FFF
reset_view p 0 0 0 0 1 400 200 0 0F0 FFF
reset_view p 0 0 0 0 1 765 75 0 CCC FFF
reset_view p 0 0 0 0 1 600 400 0 FFF FFF
reset_view p 0 0 0 0 0 450 250 0 000 FFF
start_move d 0 0 1 1 1 600 400 1 000 000
start_move p 0 0 0 0 1 600 400 0 30C 30C
start_move d 0 0 0 1 1 600 400 10 000 000
start_move p 0 0 0 0 1 470 250 0 F00 30C
start_move d 0 0 0 1 1 600 400 165 000 000
start_move p 0 0 0 0 1 800 250 0 F00 30C
start_move d 0 0 0 1 1 600 400 1 000 000
start_move p 0 0 0 0 1 150 250 0 F00 30C
apple_miss d 0 0 0 0 1 600 400 147 000 000
apple_miss p 0 0 0 0 1 300 256 0 0F0 30C
apple_miss p 0 0 0 0 1 765 75 0 30C 30C
apple_catch d 0 0 0 1 1 600 400 75 000 000
apple_catch d 0 1 0 0 1 600 400 130 000 000
apple_catch p 0 0 0 0 1 167 55 0 F00 30C
apple_catch d 0 0 0 1 1 600 400 75 000 000
apple_catch d 0 0 0 0 1 600 400 319 000 000
apple_catch d 0 0 0 1 1 600 400 160 000 000
apple_catch d 0 0 0 0 1 600 400 241 000 000
apple_catch d 0 0 1 0 1 600 400 150 000 000
apple_catch d 0 0 0 0 1 600 400 161 000 000
apple_catch d 0 0 1 0 1 600 400 160 000 000
apple_catch d 0 0 0 0 1 600 400 141 000 000
apple_catch d 0 0 1 0 1 600 400 68 000 000
apple_catch d 0 0 0 0 1 600 400 218 000 000
apple_catch p 0 0 0 0 1 167 115 0 F00 30C
apple_catch d 0 0 1 0 1 600 400 63 000 000
apple_catch d 0 0 0 0 1 600 400 349 000 000
apple_catch p 0 0 0 0 1 600 400 0 CC0 CC0
apple_catch p 0 0 0 0 1 167 55 0 CC0 CC0
apple_catch p 0 0 0 0 1 765 75 0 CCC CC0
game_over d 0 0 0 0 1 600 400 300 000 000
game_over p 0 0 0 0 1 755 75 0 CC0 CC0
game_over d 0 0 0 0 1 600 400 490 000 000
game_over p 0 0 0 0 1 600 400 0 000 000
game_over p 0 0 0 0 1 540 510 0 F00 000
game_over p 0 0 0 0 1 725 75 0 000 000
restart d 0 0 1 1 1 600 400 1 000 000
restart p 0 0 0 0 1 600 400 0 30C 30C
restart p 0 0 0 0 1 765 75 0 CCC 30C

// File: verif/tb_catch_game.sv
`timescale 1ns/100ps
`default_nettype none

module tb_catch_game;

	localparam int max_lines = 1000;
	localparam int max_hold = 2000;
	localparam int max_cycles = 20000;

	logic clk;
	logic rst;
	logic bright;
	logic up;
	logic down;
	logic left;
	logic right;
	logic [catch_pkg::coord_w-1:0] hcount;
	logic [catch_pkg::coord_w-1:0] vcount;
	logic [catch_pkg::rgb_w-1:0] rgb;
	logic [catch_pkg::rgb_w-1:0] background;
	int cycle_count;
	int pass_count;
	int fail_count;

	catch_game_top i_catch_game_top (
		.clk(clk), .rst(rst), .bright(bright),
		.up(up), .down(down), .left(left), .right(right),
		.hcount(hcount), .vcount(vcount), .rgb(rgb), .background(background)
	);

	always #20 clk = ~clk;

	always @(posedge clk)
		cycle_count <= cycle_count + 1;

	// keep the inputs for a number of falling edges
	task automatic hold_cycles(input string test, input int cycles, inout int errors);
		int n;
		n = 0;
		while ((n < cycles) && (n < max_hold))
		begin
			@(negedge clk);
			n++;
		end
		if (n < cycles)
		begin
			$display("timeout in %s, a drive line ran past the cycle limit", test);
			errors++;
		end
	endtask

	task automatic check_colour(input string test, input string what,
		input logic [11:0] expected, input logic [11:0] actual, inout int errors);
		assert (actual === expected)
		else
		begin
			$display("Error %s %s expected %h actual %h", test, what, expected, actual);
			errors++;
		end
	endtask

	task automatic finish_test(input string test, input int errors);
		if (errors == 0)
		begin
			$display("test %s passed", test);
			pass_count++;
		end
		else
		begin
			$display("test %s failed with %0d errors", test, errors);
			fail_count++;
		end
	endtask

	// whole-run limit
	initial
	begin
		while (cycle_count < max_cycles)
			@(posedge clk);
		$display("timeout, the run did not end within %0d clock cycles", max_cycles);
		$display("Simulation failed");
		$finish;
	end

	initial
	begin
		int fd;
		int line_count;
		int test_errors;
		int f [8];
		string text;
		string name;
		string op;
		string last_name;
		logic [11:0] exp_rgb;
		logic [11:0] exp_bg;
		clk = 1'b0;
		rst = 1'b1;
		{bright, up, down, left, right} = '0;
		hcount = '0;
		vcount = '0;
		pass_count = 0;
		fail_count = 0;
		test_errors = 0;
		line_count = 0;
		last_name = "";
		for (int i = 0; i < 3; i++)
			@(negedge clk);
		rst = 1'b0;
		fd = $fopen("verif/catch_trace.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the trace file");
			fail_count++;
		end
		while ((fd != 0) && !$feof(fd) && (line_count < max_lines))
		begin
			line_count++;
			if ($fgets(text, fd) == 0)
				continue;
			// comment and blank lines match fewer fields
			if ($sscanf(text, "%s %s %d %d %d %d %d %d %d %d %h %h", name, op, f[0], f[1],
				f[2], f[3], f[4], f[5], f[6], f[7], exp_rgb, exp_bg) != 12)
				continue;
			if (name != last_name)
			begin
				if (last_name != "")
					finish_test(last_name, test_errors);
				test_errors = 0;
				last_name = name;
			end
			{up, down, left, right} = (op == "d") ? {f[0] != 0, f[1] != 0, f[2] != 0,
				f[3] != 0} : {up, down, left, right};
			bright = (f[4] != 0);
			hcount = f[5][catch_pkg::coord_w-1:0];
			vcount = f[6][catch_pkg::coord_w-1:0];
			if (op == "d")
				hold_cycles(name, f[7], test_errors);
			else
			begin
				#1;
				check_colour(name, "rgb", exp_rgb, rgb, test_errors);
				check_colour(name, "background", exp_bg, background, test_errors);
			end
		end
		if (line_count >= max_lines)
		begin
			$display("timeout, the trace file has more lines than the reader allows");
			fail_count++;
		end
		if (last_name != "")
			finish_test(last_name, test_errors);
		if (i_catch_game_top.i_game_fsm.i_catch_game_properties.assert_failures != 0)
		begin
			$display("the bound concurrent assertions on the FSM failed");
			fail_count++;
		end
		$display("tests passed %0d, tests failed %0d", pass_count, fail_count);
		if ((fail_count == 0) && (pass_count > 0))
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire
